/* include/rnn_config.svh */
`ifndef RNN_CONFIG_SVH
`define RNN_CONFIG_SVH

// ---------------------------------------------------------------------------
// fixed-point format
// ---------------------------------------------------------------------------

// signed Q4.12 word
`define RNN_DATA_W 16
`define RNN_FRAC_W 12

// ---------------------------------------------------------------------------
// network shape
// ---------------------------------------------------------------------------

`define RNN_DIM 3
`define RNN_STEPS 3
// one x element and one U/W/V element per cycle
`define RNN_LOAD_LEN 9

`endif

/* logic/rnn_pkg.sv */
`default_nettype none

`include "rnn_config.svh"

package rnn_pkg;

	// Q4.12 data and weight word
	typedef logic signed [`RNN_DATA_W-1:0] fix_t;

	// sum of six 32-bit products, no overflow
	typedef logic signed [34:0] acc_t;

	// row or column of a 3x3 matrix
	typedef logic [1:0] row_t;
	typedef logic [1:0] step_t;
	typedef logic [3:0] load_idx_t;

	// 0..2 hidden rows, 3..5 output rows
	typedef logic [2:0] phase_t;

	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		CALC
	} rnn_state_t;

endpackage

`default_nettype wire

/* logic/rnn_seq_if.sv */
`default_nettype none
`timescale 1ns/100ps

interface rnn_seq_if;
	import rnn_pkg::*;

	// load side
	logic load_en;
	load_idx_t load_idx;

	// operand selection
	step_t step;
	row_t row;

	// datapath strobes
	logic hidden_en;
	logic out_en;
	logic clear_state;

	modport ctrl (
		output load_en, load_idx, step, row,
		output hidden_en, out_en, clear_state
	);

	modport store (input load_en, load_idx, step, row);

	// row also addresses the hidden bank
	modport datapath (input hidden_en, out_en, clear_state, row);

endinterface

`default_nettype wire

/* logic/rnn_step_counter.sv */
`default_nettype none
`timescale 1ns/100ps

`include "rnn_config.svh"

module rnn_step_counter (
	input  logic clk,
	input  logic rst_n,
	input  logic clear,
	input  logic advance,
	output rnn_pkg::load_idx_t load_idx,
	output rnn_pkg::phase_t phase,
	output rnn_pkg::step_t step,
	output logic load_done,
	output logic calc_done
);
	import rnn_pkg::*;

	localparam load_idx_t LOAD_LAST = load_idx_t'(`RNN_LOAD_LEN - 1);
	localparam phase_t PHASE_LAST = phase_t'(2 * `RNN_DIM - 1);
	localparam step_t STEP_LAST = step_t'(`RNN_STEPS - 1);

	// low while loading, high while computing
	logic calc_mode;
	logic phase_wrap;

	assign phase_wrap = calc_mode && (phase == PHASE_LAST);
	assign load_done = !calc_mode && (load_idx == LOAD_LAST);
	assign calc_done = phase_wrap && (step == STEP_LAST);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			calc_mode <= 1'b0;
			load_idx <= '0;
			phase <= '0;
			step <= '0;
		end else if (clear) begin
			calc_mode <= 1'b0;
			load_idx <= '0;
			phase <= '0;
			step <= '0;
		end else if (advance) begin
			if (!calc_mode) begin
				// last element hands over to the compute count
				if (load_done) begin
					calc_mode <= 1'b1;
					load_idx <= '0;
				end else begin
					load_idx <= load_idx + 1'b1;
				end
			end else if (phase_wrap) begin
				phase <= '0;
				if (calc_done) begin
					calc_mode <= 1'b0;
					step <= '0;
				end else begin
					step <= step + 1'b1;
				end
			end else begin
				phase <= phase + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* logic/rnn_ctrl.sv */
`default_nettype none
`timescale 1ns/100ps

`include "rnn_config.svh"

module rnn_ctrl (
	input  logic clk,
	input  logic rst_n,
	input  logic in_valid,
	rnn_seq_if.ctrl seq
);
	import rnn_pkg::*;

	// first output phase of a step
	localparam phase_t PHASE_OUT = phase_t'(`RNN_DIM);

	rnn_state_t state;
	rnn_state_t state_nxt;

	logic accept;
	logic advance;
	logic cnt_clear;
	load_idx_t load_idx;
	phase_t phase;
	step_t step;
	logic load_done;
	logic calc_done;
	phase_t row_phase;

	// in_valid only counts outside CALC
	assign accept = in_valid && (state != CALC);
	assign advance = accept || (state == CALC);
	// park the counter at zero whenever nothing is loading
	assign cnt_clear = !accept && (state != CALC);

	rnn_step_counter i_counter (
		.clk       (clk),
		.rst_n     (rst_n),
		.clear     (cnt_clear),
		.advance   (advance),
		.load_idx  (load_idx),
		.phase     (phase),
		.step      (step),
		.load_done (load_done),
		.calc_done (calc_done)
	);

	// ---------------------------------------------------------------------------
	// state register
	// ---------------------------------------------------------------------------

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: if (accept) state_nxt = LOAD;
			// a gap in the load stream aborts the sequence
			LOAD: if (!in_valid) state_nxt = IDLE;
				else if (load_done) state_nxt = CALC;
			CALC: if (calc_done) state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// ---------------------------------------------------------------------------
	// sequence decode
	// ---------------------------------------------------------------------------

	assign row_phase = (phase < PHASE_OUT) ? phase : phase - PHASE_OUT;

	assign seq.load_en = accept;
	assign seq.load_idx = load_idx;
	assign seq.step = step;
	assign seq.row = row_t'(row_phase);
	assign seq.hidden_en = (state == CALC) && (phase < PHASE_OUT);
	assign seq.out_en = (state == CALC) && (phase >= PHASE_OUT);
	assign seq.clear_state = accept && (state == IDLE);

endmodule

`default_nettype wire

/* logic/rnn_operand_store.sv */
`default_nettype none
`timescale 1ns/100ps

`include "rnn_config.svh"

module rnn_operand_store (
	input  logic clk,
	input  logic rst_n,
	rnn_seq_if.store seq,
	input  rnn_pkg::fix_t data_x,
	input  rnn_pkg::fix_t weight_u,
	input  rnn_pkg::fix_t weight_w,
	input  rnn_pkg::fix_t weight_v,
	output rnn_pkg::fix_t x_vec [`RNN_DIM],
	output rnn_pkg::fix_t u_row [`RNN_DIM],
	output rnn_pkg::fix_t w_row [`RNN_DIM],
	output rnn_pkg::fix_t v_row [`RNN_DIM]
);
	import rnn_pkg::*;

	// x is indexed [step][feature], the matrices [row][col]
	fix_t x_mem [`RNN_DIM][`RNN_DIM];
	fix_t u_mem [`RNN_DIM][`RNN_DIM];
	fix_t w_mem [`RNN_DIM][`RNN_DIM];
	fix_t v_mem [`RNN_DIM][`RNN_DIM];

	row_t wr_row;
	row_t wr_col;

	// element k lands at [k/3][k%3]
	assign wr_row = row_t'(seq.load_idx / load_idx_t'(`RNN_DIM));
	assign wr_col = row_t'(seq.load_idx % load_idx_t'(`RNN_DIM));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			x_mem <= '{default: '0};
			u_mem <= '{default: '0};
			w_mem <= '{default: '0};
			v_mem <= '{default: '0};
		end else if (seq.load_en) begin
			x_mem[wr_row][wr_col] <= data_x;
			u_mem[wr_row][wr_col] <= weight_u;
			w_mem[wr_row][wr_col] <= weight_w;
			v_mem[wr_row][wr_col] <= weight_v;
		end
	end

	// ---------------------------------------------------------------------------
	// zero-latency read ports
	// ---------------------------------------------------------------------------

	assign x_vec = x_mem[seq.step];
	assign u_row = u_mem[seq.row];
	assign w_row = w_mem[seq.row];
	assign v_row = v_mem[seq.row];

endmodule

`default_nettype wire

/* logic/rnn_cell_datapath.sv */
`default_nettype none
`timescale 1ns/100ps

`include "rnn_config.svh"

module rnn_cell_datapath (
	input  logic clk,
	input  logic rst_n,
	rnn_seq_if.datapath seq,
	input  rnn_pkg::fix_t x_vec [`RNN_DIM],
	input  rnn_pkg::fix_t u_row [`RNN_DIM],
	input  rnn_pkg::fix_t w_row [`RNN_DIM],
	input  rnn_pkg::fix_t v_row [`RNN_DIM],
	output logic out_valid,
	output rnn_pkg::fix_t out
);
	import rnn_pkg::*;

	localparam fix_t FIX_ONE = fix_t'(1 << `RNN_FRAC_W);
	localparam fix_t FIX_HALF = fix_t'(1 << (`RNN_FRAC_W - 1));
	localparam acc_t SAT_HI = acc_t'((1 << (`RNN_DATA_W - 1)) - 1);
	localparam acc_t SAT_LO = acc_t'(-(1 << (`RNN_DATA_W - 1)));
	localparam row_t ROW_LAST = row_t'(`RNN_DIM - 1);

	// h(t-1) and h(t)
	fix_t h_prev [`RNN_DIM];
	fix_t h_cur [`RNN_DIM];

	acc_t rec_sum;
	acc_t out_sum;
	acc_t hid_acc;
	fix_t hid_val;
	fix_t out_sat;

	function automatic fix_t sat_fix(input acc_t val);
		fix_t res;
		if (val > SAT_HI) begin
			res = fix_t'(SAT_HI);
		end else if (val < SAT_LO) begin
			res = fix_t'(SAT_LO);
		end else begin
			res = fix_t'(val);
		end
		return res;
	endfunction

	// ---------------------------------------------------------------------------
	// dot products, full precision
	// ---------------------------------------------------------------------------

	always_comb begin
		rec_sum = '0;
		out_sum = '0;
		for (int i = 0; i < `RNN_DIM; i++) begin
			rec_sum = rec_sum + acc_t'(u_row[i]) * acc_t'(x_vec[i]);
			rec_sum = rec_sum + acc_t'(w_row[i]) * acc_t'(h_prev[i]);
			out_sum = out_sum + acc_t'(v_row[i]) * acc_t'(h_cur[i]);
		end
	end

	// hard sigmoid: s/4 + 0.5 clamped to [0, 1]
	always_comb begin
		hid_acc = ((rec_sum >>> `RNN_FRAC_W) >>> 2) + acc_t'(FIX_HALF);
		if (hid_acc < 0) begin
			hid_val = '0;
		end else if (hid_acc > acc_t'(FIX_ONE)) begin
			hid_val = FIX_ONE;
		end else begin
			hid_val = fix_t'(hid_acc);
		end
	end

	assign out_sat = sat_fix(out_sum >>> `RNN_FRAC_W);

	// ---------------------------------------------------------------------------
	// hidden banks
	// ---------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (seq.clear_state) begin
			h_prev <= '{default: '0};
			h_cur <= '{default: '0};
		end else begin
			if (seq.hidden_en) begin
				h_cur[seq.row] <= hid_val;
			end
			// last output row done, h(t) becomes h(t-1)
			if (seq.out_en && (seq.row == ROW_LAST)) begin
				h_prev <= h_cur;
			end
		end
	end

	// relu on the way out
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			out <= '0;
		end else begin
			out_valid <= seq.out_en;
			out <= (seq.out_en && !out_sat[`RNN_DATA_W-1]) ? out_sat : '0;
		end
	end

endmodule

`default_nettype wire

/* logic/rnn_top.sv */
`default_nettype none
`timescale 1ns/100ps

`include "rnn_config.svh"

module rnn_top (
	input  logic clk,
	input  logic rst_n,
	input  logic in_valid,
	input  rnn_pkg::fix_t data_x,
	input  rnn_pkg::fix_t weight_u,
	input  rnn_pkg::fix_t weight_w,
	input  rnn_pkg::fix_t weight_v,
	output logic out_valid,
	output rnn_pkg::fix_t out
);
	import rnn_pkg::*;

	rnn_seq_if seq ();

	// operands from the store, selected by step and row
	fix_t x_vec [`RNN_DIM];
	fix_t u_row [`RNN_DIM];
	fix_t w_row [`RNN_DIM];
	fix_t v_row [`RNN_DIM];

	rnn_ctrl i_ctrl (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.seq      (seq)
	);

	rnn_operand_store i_store (
		.clk      (clk),
		.rst_n    (rst_n),
		.seq      (seq),
		.data_x   (data_x),
		.weight_u (weight_u),
		.weight_w (weight_w),
		.weight_v (weight_v),
		.x_vec    (x_vec),
		.u_row    (u_row),
		.w_row    (w_row),
		.v_row    (v_row)
	);

	rnn_cell_datapath i_datapath (
		.clk       (clk),
		.rst_n     (rst_n),
		.seq       (seq),
		.x_vec     (x_vec),
		.u_row     (u_row),
		.w_row     (w_row),
		.v_row     (v_row),
		.out_valid (out_valid),
		.out       (out)
	);

endmodule

`default_nettype wire

/* dv/rnn_assert.sv */
`default_nettype none
`timescale 1ns/100ps

module rnn_assert (
	input  logic clk,
	input  logic rst_n,
	input  logic out_valid,
	input  rnn_pkg::fix_t out
);

	// output held at zero outside valid cycles
	a_out_zero: assert property (@(posedge clk) disable iff (!rst_n)
		!out_valid |-> (out == '0))
		else $error("out is nonzero while out_valid is low");

	// relu output, sign bit never set
	a_out_nonneg: assert property (@(posedge clk) disable iff (!rst_n)
		!out[$bits(out)-1])
		else $error("out is negative");

	// one group is three rows long
	a_valid_run: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && $past(out_valid) && $past(out_valid, 2) |=> !out_valid)
		else $error("out_valid high for more than three cycles");

endmodule

bind rnn_top rnn_assert i_assert (
	.clk       (clk),
	.rst_n     (rst_n),
	.out_valid (out_valid),
	.out       (out)
);

`default_nettype wire

/* dv/rnn_tb.sv */
`default_nettype none
`timescale 1ns/100ps

`include "rnn_config.svh"

module rnn_tb;
	import rnn_pkg::*;

	localparam int NUM_SEQ = 14;
	localparam int TIMEOUT_CYCLES = NUM_SEQ * 40 + 100;
	localparam int CALC_CYCLES = 2 * `RNN_DIM * `RNN_STEPS;
	localparam int OUTS_PER_SEQ = `RNN_DIM * `RNN_STEPS;

	logic clk;
	logic rst_n;
	logic in_valid;
	fix_t data_x;
	fix_t weight_u;
	fix_t weight_w;
	fix_t weight_v;
	logic out_valid;
	fix_t out;

	logic [31:0] lfsr_state;
	fix_t x_m [`RNN_DIM][`RNN_DIM];
	fix_t u_m [`RNN_DIM][`RNN_DIM];
	fix_t w_m [`RNN_DIM][`RNN_DIM];
	fix_t v_m [`RNN_DIM][`RNN_DIM];
	fix_t exp_q [$];
	int err_cnt;
	int valid_cnt;
	int pass_cnt;
	int fail_cnt;
	int cycle_cnt;

	rnn_top i_rnn_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.data_x    (data_x),
		.weight_u  (weight_u),
		.weight_w  (weight_w),
		.weight_v  (weight_v),
		.out_valid (out_valid),
		.out       (out)
	);

	always #10 clk = ~clk;

	// ------------------------------------------------------------------------
	// random source and checks
	// ------------------------------------------------------------------------

	// x^32 + x^22 + x^2 + x + 1, one step per bit
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] val;
		logic fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			val = {val[30:0], fb};
		end
		return val;
	endfunction

	// uniform in -lim..lim
	function automatic fix_t rand_val(input int lim);
		int unsigned raw;
		raw = lfsr_bits(16);
		return fix_t'(int'(raw % (2 * lim + 1)) - lim);
	endfunction

	task automatic check_fix(input string name, input fix_t exp, input fix_t act);
		if (exp !== act) begin
			$display("[FAIL] %s: expected 0x%h, got 0x%h", name, exp, act);
			err_cnt++;
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (exp != act) begin
			$display("[FAIL] %s count: expected 0x%h, got 0x%h", name, exp, act);
			err_cnt++;
		end
	endtask

	// ------------------------------------------------------------------------
	// operands and reference model
	// ------------------------------------------------------------------------

	task automatic gen_operands(input int lim, input bit neg_v);
		for (int r = 0; r < `RNN_DIM; r++) begin
			for (int c = 0; c < `RNN_DIM; c++) begin
				x_m[r][c] = rand_val(lim);
				u_m[r][c] = rand_val(lim);
				w_m[r][c] = rand_val(lim);
				v_m[r][c] = neg_v ? fix_t'(-(int'(lfsr_bits(16)) % lim) - 1) : rand_val(lim);
			end
		end
	endtask

	task automatic model_sequence();
		longint h_prev [`RNN_DIM];
		longint h_cur [`RNN_DIM];
		longint s;
		longint o;
		for (int c = 0; c < `RNN_DIM; c++) begin
			h_prev[c] = 0;
			h_cur[c] = 0;
		end
		for (int t = 0; t < `RNN_STEPS; t++) begin
			for (int r = 0; r < `RNN_DIM; r++) begin
				s = 0;
				for (int c = 0; c < `RNN_DIM; c++) begin
					s += longint'(u_m[r][c]) * longint'(x_m[t][c]);
					s += longint'(w_m[r][c]) * h_prev[c];
				end
				// hard sigmoid in Q4.12
				s = ((s >>> 12) >>> 2) + 2048;
				h_cur[r] = (s < 0) ? 0 : (s > 4096) ? 4096 : s;
			end
			for (int r = 0; r < `RNN_DIM; r++) begin
				o = 0;
				for (int c = 0; c < `RNN_DIM; c++) begin
					o += longint'(v_m[r][c]) * h_cur[c];
				end
				o = o >>> 12;
				o = (o > 32767) ? 32767 : (o < 0) ? 0 : o;
				exp_q.push_back(fix_t'(o));
			end
			h_prev = h_cur;
		end
	endtask

	// ------------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------------

	task automatic idle_inputs();
		@(posedge clk);
		#2;
		in_valid = 1'b0;
		data_x = '0;
		weight_u = '0;
		weight_w = '0;
		weight_v = '0;
	endtask

	// nine load cycles, then the fixed compute window
	task automatic drive_sequence(input bit pulses);
		for (int k = 0; k < `RNN_LOAD_LEN; k++) begin
			@(posedge clk);
			#2;
			in_valid = 1'b1;
			data_x = x_m[k / `RNN_DIM][k % `RNN_DIM];
			weight_u = u_m[k / `RNN_DIM][k % `RNN_DIM];
			weight_w = w_m[k / `RNN_DIM][k % `RNN_DIM];
			weight_v = v_m[k / `RNN_DIM][k % `RNN_DIM];
		end
		for (int c = 0; c < CALC_CYCLES; c++) begin
			@(posedge clk);
			#2;
			in_valid = pulses ? (lfsr_bits(1) != 0) : 1'b0;
			if (pulses) begin
				data_x = fix_t'(lfsr_bits(16));
				weight_u = fix_t'(lfsr_bits(16));
				weight_w = fix_t'(lfsr_bits(16));
				weight_v = fix_t'(lfsr_bits(16));
			end
		end
	endtask

	// a stray group would show up inside four cycles
	task automatic wait_results();
		while (exp_q.size() != 0) begin
			@(negedge clk);
		end
		repeat (4) @(negedge clk);
	endtask

	task automatic run_test(input string name, input int nseq, input int lim,
			input bit neg_v, input bit pulses, input bit chained);
		int err_before;
		int seq_lim;
		err_before = err_cnt;
		valid_cnt = 0;
		for (int i = 0; i < nseq; i++) begin
			// chained run starts from a saturating sequence
			seq_lim = (chained && i == 0) ? 32767 : lim;
			gen_operands(seq_lim, neg_v);
			model_sequence();
			drive_sequence(pulses);
			if (!chained) begin
				idle_inputs();
				wait_results();
			end
		end
		if (chained) begin
			idle_inputs();
			wait_results();
		end
		check_count("out_valid", OUTS_PER_SEQ * nseq, valid_cnt);
		if (err_cnt == err_before) begin
			pass_cnt++;
			$display("test %s: pass", name);
		end else begin
			fail_cnt++;
			$display("test %s: fail, %0d errors", name, err_cnt - err_before);
		end
	endtask

	// output monitor, sampled away from the active edge
	always @(negedge clk) begin
		if (rst_n) begin
			if (out_valid) begin
				valid_cnt++;
				if (exp_q.size() == 0) begin
					$display("out_valid rose with no result pending");
					err_cnt++;
				end else begin
					check_fix("out", exp_q.pop_front(), out);
				end
			end else begin
				check_fix("out", '0, out);
			end
		end
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, results still pending", cycle_cnt);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		in_valid = 1'b0;
		data_x = '0;
		weight_u = '0;
		weight_w = '0;
		weight_v = '0;
		lfsr_state = 32'd96649;
		err_cnt = 0;
		valid_cnt = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		cycle_cnt = 0;
		repeat (10) @(posedge clk);
		#2;
		rst_n = 1'b1;

		run_test("small_random", 4, 4096, 1'b0, 1'b0, 1'b0);
		run_test("back_to_back", 2, 4096, 1'b0, 1'b0, 1'b1);
		run_test("saturation", 3, 32767, 1'b0, 1'b0, 1'b0);
		run_test("negative_v", 2, 4096, 1'b1, 1'b0, 1'b0);
		run_test("valid_count", 1, 4096, 1'b0, 1'b0, 1'b0);
		run_test("calc_pulses", 2, 4096, 1'b0, 1'b1, 1'b0);

		$display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
		if (err_cnt == 0 && fail_cnt == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
+incdir+include
logic/rnn_pkg.sv
logic/rnn_seq_if.sv
logic/rnn_step_counter.sv
logic/rnn_ctrl.sv
logic/rnn_operand_store.sv
logic/rnn_cell_datapath.sv
logic/rnn_top.sv
dv/rnn_assert.sv
dv/rnn_tb.sv

/* Makefile */
# Verilator build and run for the RNN inference engine

TOP := rnn_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

obj_dir/V$(TOP): compile.f $(wildcard logic/*.sv dv/*.sv include/*.svh)
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o V$(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	! grep -q "SIMULATION FAILED" $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
